// File: verilog/riscv_pkg.sv
package riscv_pkg;

    localparam int xlen = 32;
    localparam int reg_addr_w = 5;

    // major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        op_r        = 7'b0110011,
        op_imm      = 7'b0010011,
        op_load     = 7'b0000011,
        op_store    = 7'b0100011,
        op_branch   = 7'b1100011,
        op_jal      = 7'b1101111,
        op_jalr     = 7'b1100111,
        op_lui      = 7'b0110111,
        op_auipc    = 7'b0010111,
        op_system   = 7'b1110011,
        op_fp_load  = 7'b0000111,
        op_fp_store = 7'b0100111,
        op_fp       = 7'b1010011,
        op_fmadd    = 7'b1000011,
        op_fmsub    = 7'b1000111,
        op_fnmsub   = 7'b1001011,
        op_fnmadd   = 7'b1001111
    } opcode_e;

    typedef enum logic [2:0] {
        imm_i,
        imm_s,
        imm_b,
        imm_u,
        imm_j
    } imm_src_e;

    // alu_ prefix since and/or/xor are keywords
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b
    } alu_ctrl_e;

    typedef enum logic [1:0] {
        res_alu,
        res_mem,
        res_pc_plus4
    } result_src_e;

    typedef struct packed {
        logic        reg_write;
        logic        fpu_reg_write;
        logic        mem_write;
        result_src_e result_src;
        logic        branch;
        logic        jump;
        logic        alu_src;
        alu_ctrl_e   alu_ctrl;
        logic        csr_write;
        logic        illegal;
    } ctrl_t;

endpackage

// File: verilog/data_fetch_io.sv
`timescale 1ns/1ps

interface data_fetch_io (
    input logic clk
);
    logic [riscv_pkg::xlen-1:0] pc;
    logic [riscv_pkg::xlen-1:0] pc_plus4;
    logic [riscv_pkg::xlen-1:0] instr;
    logic                       valid;

    modport producer (
        output pc,
        output pc_plus4,
        output instr,
        output valid
    );

    modport buffer_in (
        input pc,
        input pc_plus4,
        input instr,
        input valid
    );

    modport buffer_out (
        output pc,
        output pc_plus4,
        output instr,
        output valid
    );

    modport consumer (
        input pc,
        input pc_plus4,
        input instr,
        input valid
    );

endinterface

// File: verilog/instr_fetch.sv
`timescale 1ns/1ps

module instr_fetch (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [riscv_pkg::xlen-1:0] instr_in,
    input  logic                       instr_valid,
    input  logic                       stall,
    input  logic                       redirect,
    input  logic [riscv_pkg::xlen-1:0] redirect_pc,
    data_fetch_io.producer             fetch_if
);
    logic [riscv_pkg::xlen-1:0] pc;
    logic                       accept;

    assign accept = instr_valid && !stall;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (redirect) begin
            // offered word is dropped, pc jumps
            pc <= redirect_pc;
        end else if (accept) begin
            pc <= pc + 32'd4;
        end
    end

    assign fetch_if.pc       = pc;
    assign fetch_if.pc_plus4 = pc + 32'd4;
    assign fetch_if.instr    = instr_in;
    assign fetch_if.valid    = accept;

    // only redirect_pc can break alignment
    assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00);

endmodule

// File: verilog/fetch_decode_reg.sv
`timescale 1ns/1ps

module fetch_decode_reg (
    input  logic             clk,
    input  logic             rst,
    input  logic             stall,
    input  logic             redirect,
    data_fetch_io.buffer_in  in_if,
    data_fetch_io.buffer_out out_if
);
    logic [riscv_pkg::xlen-1:0] pc_q;
    logic [riscv_pkg::xlen-1:0] pc_plus4_q;
    logic [riscv_pkg::xlen-1:0] instr_q;
    logic                       valid_q;

    always_ff @(posedge clk) begin
        if (rst || redirect) begin
            valid_q <= 1'b0;
        end else if (!stall) begin
            valid_q <= in_if.valid;
        end
    end

    // payload
    always_ff @(posedge clk) begin
        if (!stall) begin
            pc_q       <= in_if.pc;
            pc_plus4_q <= in_if.pc_plus4;
            instr_q    <= in_if.instr;
        end
    end

    assign out_if.pc       = pc_q;
    assign out_if.pc_plus4 = pc_plus4_q;
    assign out_if.instr    = instr_q;
    assign out_if.valid    = valid_q;

    assert property (@(posedge clk) disable iff (rst)
        stall && !redirect |=> $stable(out_if.valid));

endmodule

// File: verilog/control_unit.sv
`timescale 1ns/1ps

module control_unit (
    input  logic [riscv_pkg::xlen-1:0] instr,
    input  logic                       valid,
    output riscv_pkg::ctrl_t           ctrl,
    output riscv_pkg::imm_src_e        imm_src,
    output logic                       r4
);
    riscv_pkg::opcode_e   opcode;
    riscv_pkg::alu_ctrl_e alu_op;
    logic [2:0]           funct3;
    logic                 funct7_5;
    logic [4:0]           funct7_top;
    logic                 fp_to_int;

    assign opcode     = riscv_pkg::opcode_e'(instr[6:0]);
    assign funct3     = instr[14:12];
    assign funct7_5   = instr[30];
    assign funct7_top = instr[31:27];

    // fcmp, fcvt.w, fmv.x.w/fclass land in the integer file
    assign fp_to_int = (funct7_top == 5'b10100) || (funct7_top == 5'b11000)
                    || (funct7_top == 5'b11100);

    // alu decoder, sub only for register-register
    always_comb begin
        case (funct3)
            3'b000: begin
                alu_op = (opcode == riscv_pkg::op_r && funct7_5) ? riscv_pkg::alu_sub
                                                                  : riscv_pkg::alu_add;
            end
            3'b001: alu_op = riscv_pkg::alu_sll;
            3'b010: alu_op = riscv_pkg::alu_slt;
            3'b011: alu_op = riscv_pkg::alu_sltu;
            3'b100: alu_op = riscv_pkg::alu_xor;
            3'b101: alu_op = funct7_5 ? riscv_pkg::alu_sra : riscv_pkg::alu_srl;
            3'b110: alu_op = riscv_pkg::alu_or;
            default: alu_op = riscv_pkg::alu_and;
        endcase
    end

    always_comb begin
        ctrl    = '0;
        imm_src = riscv_pkg::imm_i;
        r4      = 1'b0;
        if (valid) begin
            case (opcode)
                riscv_pkg::op_r: begin
                    ctrl.reg_write = 1'b1;
                    ctrl.alu_ctrl  = alu_op;
                end
                riscv_pkg::op_imm: begin
                    ctrl.reg_write = 1'b1;
                    ctrl.alu_src   = 1'b1;
                    ctrl.alu_ctrl  = alu_op;
                end
                riscv_pkg::op_load, riscv_pkg::op_fp_load: begin
                    ctrl.reg_write     = (opcode == riscv_pkg::op_load);
                    ctrl.fpu_reg_write = (opcode == riscv_pkg::op_fp_load);
                    ctrl.result_src    = riscv_pkg::res_mem;
                    ctrl.alu_src       = 1'b1;
                end
                riscv_pkg::op_store, riscv_pkg::op_fp_store: begin
                    ctrl.mem_write = 1'b1;
                    ctrl.alu_src   = 1'b1;
                    imm_src        = riscv_pkg::imm_s;
                end
                riscv_pkg::op_branch: begin
                    ctrl.branch   = 1'b1;
                    ctrl.alu_ctrl = riscv_pkg::alu_sub;
                    imm_src       = riscv_pkg::imm_b;
                end
                riscv_pkg::op_jal, riscv_pkg::op_jalr: begin
                    ctrl.reg_write  = 1'b1;
                    ctrl.jump       = 1'b1;
                    ctrl.result_src = riscv_pkg::res_pc_plus4;
                    ctrl.alu_src    = (opcode == riscv_pkg::op_jalr);
                    imm_src = (opcode == riscv_pkg::op_jal) ? riscv_pkg::imm_j
                                                            : riscv_pkg::imm_i;
                end
                riscv_pkg::op_lui, riscv_pkg::op_auipc: begin
                    ctrl.reg_write = 1'b1;
                    ctrl.alu_src   = 1'b1;
                    ctrl.alu_ctrl  = (opcode == riscv_pkg::op_lui) ? riscv_pkg::alu_pass_b
                                                                    : riscv_pkg::alu_add;
                    imm_src        = riscv_pkg::imm_u;
                end
                riscv_pkg::op_system: begin
                    // csrrw/s/c and immediate forms, ecall/ebreak not handled
                    if (funct3[1:0] != 2'b00) begin
                        ctrl.reg_write = 1'b1;
                        ctrl.csr_write = 1'b1;
                        ctrl.alu_ctrl  = riscv_pkg::alu_pass_b;
                    end else begin
                        ctrl.illegal = 1'b1;
                    end
                end
                riscv_pkg::op_fp: begin
                    ctrl.reg_write     = fp_to_int;
                    ctrl.fpu_reg_write = !fp_to_int;
                end
                riscv_pkg::op_fmadd, riscv_pkg::op_fmsub,
                riscv_pkg::op_fnmsub, riscv_pkg::op_fnmadd: begin
                    ctrl.fpu_reg_write = 1'b1;
                    r4                 = 1'b1;
                end
                default: ctrl.illegal = 1'b1;
            endcase
        end
    end

endmodule

// File: verilog/extend.sv
`timescale 1ns/1ps

module extend (
    input  logic [riscv_pkg::xlen-1:0] instr,
    input  riscv_pkg::imm_src_e        imm_src,
    output logic [riscv_pkg::xlen-1:0] imm_ext
);
    always_comb begin
        case (imm_src)
            riscv_pkg::imm_i: begin
                imm_ext = {{20{instr[31]}}, instr[31:20]};
            end
            riscv_pkg::imm_s: begin
                imm_ext = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            riscv_pkg::imm_b: begin
                imm_ext = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            riscv_pkg::imm_u: begin
                imm_ext = {instr[31:12], 12'b0};
            end
            riscv_pkg::imm_j: begin
                imm_ext = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            default: imm_ext = '0;
        endcase
    end

endmodule

// File: verilog/regfile.sv
`timescale 1ns/1ps

module regfile #(
    parameter bit zero_reg = 1'b1
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             we,
    input  logic [riscv_pkg::reg_addr_w-1:0] a1,
    input  logic [riscv_pkg::reg_addr_w-1:0] a2,
    input  logic [riscv_pkg::reg_addr_w-1:0] a3,
    input  logic [riscv_pkg::reg_addr_w-1:0] wa,
    input  logic [riscv_pkg::xlen-1:0]       wd,
    output logic [riscv_pkg::xlen-1:0]       rd1,
    output logic [riscv_pkg::xlen-1:0]       rd2,
    output logic [riscv_pkg::xlen-1:0]       rd3
);
    logic [riscv_pkg::xlen-1:0] mem [32];
    logic                       wr_en;

    assign wr_en = we && !(zero_reg && wa == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_en) begin
            mem[wa] <= wd;
        end
    end

    // write-through so decode sees this cycle's write-back
    assign rd1 = (zero_reg && a1 == '0) ? '0 : (wr_en && wa == a1) ? wd : mem[a1];
    assign rd2 = (zero_reg && a2 == '0) ? '0 : (wr_en && wa == a2) ? wd : mem[a2];
    assign rd3 = (zero_reg && a3 == '0) ? '0 : (wr_en && wa == a3) ? wd : mem[a3];

endmodule

// File: verilog/instr_decode.sv
`timescale 1ns/1ps

module instr_decode (
    input  logic                             clk,
    input  logic                             rst,
    data_fetch_io.consumer                   decode_if,
    input  logic [riscv_pkg::reg_addr_w-1:0] wb_rd,
    input  logic [riscv_pkg::xlen-1:0]       wb_data,
    input  logic                             wb_reg_write,
    input  logic                             wb_fpu_reg_write,
    output riscv_pkg::ctrl_t                 ctrl,
    output logic                             r4,
    output logic                             valid,
    output logic [riscv_pkg::xlen-1:0]       pc,
    output logic [riscv_pkg::xlen-1:0]       pc_plus4,
    output logic [riscv_pkg::xlen-1:0]       rd1,
    output logic [riscv_pkg::xlen-1:0]       rd2,
    output logic [riscv_pkg::xlen-1:0]       fpu_rd1,
    output logic [riscv_pkg::xlen-1:0]       fpu_rd2,
    output logic [riscv_pkg::xlen-1:0]       fpu_rd3,
    output logic [riscv_pkg::xlen-1:0]       imm_ext,
    output logic [riscv_pkg::reg_addr_w-1:0] rs1,
    output logic [riscv_pkg::reg_addr_w-1:0] rs2,
    output logic [riscv_pkg::reg_addr_w-1:0] rs3,
    output logic [riscv_pkg::reg_addr_w-1:0] rd,
    output logic [4:0]                       funct5,
    output logic [2:0]                       rm
);
    riscv_pkg::imm_src_e imm_src;

    assign valid    = decode_if.valid;
    assign pc       = decode_if.pc;
    assign pc_plus4 = decode_if.pc_plus4;
    assign rs1      = decode_if.instr[19:15];
    assign rs2      = decode_if.instr[24:20];
    // rs3 only meaningful for fused ops
    assign rs3      = decode_if.instr[31:27];
    assign rd       = decode_if.instr[11:7];
    assign rm       = decode_if.instr[14:12];
    assign funct5   = r4 ? decode_if.instr[6:2] : decode_if.instr[31:27];

    control_unit u_control_unit (
        .instr   (decode_if.instr),
        .valid   (decode_if.valid),
        .ctrl    (ctrl),
        .imm_src (imm_src),
        .r4      (r4)
    );

    extend u_extend (
        .instr   (decode_if.instr),
        .imm_src (imm_src),
        .imm_ext (imm_ext)
    );

    regfile #(.zero_reg(1'b1)) int_rf (
        .clk(clk), .rst(rst), .we(wb_reg_write),
        .a1(rs1), .a2(rs2), .a3(rs3), .wa(wb_rd), .wd(wb_data),
        .rd1(rd1), .rd2(rd2), .rd3()
    );

    regfile #(.zero_reg(1'b0)) fpu_rf (
        .clk(clk), .rst(rst), .we(wb_fpu_reg_write),
        .a1(rs1), .a2(rs2), .a3(rs3), .wa(wb_rd), .wd(wb_data),
        .rd1(fpu_rd1), .rd2(fpu_rd2), .rd3(fpu_rd3)
    );

endmodule

// File: verilog/decode_top.sv
`timescale 1ns/1ps

module decode_top (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [riscv_pkg::xlen-1:0]       instr_in,
    input  logic                             instr_valid,
    input  logic                             stall,
    input  logic                             redirect,
    input  logic [riscv_pkg::xlen-1:0]       redirect_pc,
    input  logic [riscv_pkg::reg_addr_w-1:0] wb_rd,
    input  logic [riscv_pkg::xlen-1:0]       wb_data,
    input  logic                             wb_reg_write,
    input  logic                             wb_fpu_reg_write,
    output logic                             dec_valid,
    output logic [riscv_pkg::xlen-1:0]       dec_pc,
    output logic [riscv_pkg::xlen-1:0]       dec_pc_plus4,
    output logic [riscv_pkg::xlen-1:0]       dec_rd1,
    output logic [riscv_pkg::xlen-1:0]       dec_rd2,
    output logic [riscv_pkg::xlen-1:0]       dec_fpu_rd1,
    output logic [riscv_pkg::xlen-1:0]       dec_fpu_rd2,
    output logic [riscv_pkg::xlen-1:0]       dec_fpu_rd3,
    output logic [riscv_pkg::xlen-1:0]       dec_imm_ext,
    output logic [riscv_pkg::reg_addr_w-1:0] dec_rs1,
    output logic [riscv_pkg::reg_addr_w-1:0] dec_rs2,
    output logic [riscv_pkg::reg_addr_w-1:0] dec_rs3,
    output logic [riscv_pkg::reg_addr_w-1:0] dec_rd,
    output logic [4:0]                       dec_funct5,
    output logic [2:0]                       dec_rm,
    output logic                             dec_r4,
    output logic                             dec_reg_write,
    output logic                             dec_fpu_reg_write,
    output logic                             dec_mem_write,
    output logic [1:0]                       dec_result_src,
    output logic                             dec_branch,
    output logic                             dec_jump,
    output logic                             dec_alu_src,
    output logic [3:0]                       dec_alu_ctrl,
    output logic                             dec_csr_write,
    output logic                             dec_illegal
);
    riscv_pkg::ctrl_t dec_ctrl;

    data_fetch_io fetch_if (.clk(clk));
    data_fetch_io decode_if (.clk(clk));

    instr_fetch u_fetch (
        .clk(clk), .rst(rst), .instr_in(instr_in), .instr_valid(instr_valid),
        .stall(stall), .redirect(redirect), .redirect_pc(redirect_pc),
        .fetch_if(fetch_if.producer)
    );

    fetch_decode_reg u_fd_reg (
        .clk(clk), .rst(rst), .stall(stall), .redirect(redirect),
        .in_if(fetch_if.buffer_in), .out_if(decode_if.buffer_out)
    );

    instr_decode u_decode (
        .clk(clk), .rst(rst), .decode_if(decode_if.consumer),
        .wb_rd(wb_rd), .wb_data(wb_data), .wb_reg_write(wb_reg_write),
        .wb_fpu_reg_write(wb_fpu_reg_write), .ctrl(dec_ctrl), .r4(dec_r4),
        .valid(dec_valid), .pc(dec_pc), .pc_plus4(dec_pc_plus4),
        .rd1(dec_rd1), .rd2(dec_rd2), .fpu_rd1(dec_fpu_rd1), .fpu_rd2(dec_fpu_rd2),
        .fpu_rd3(dec_fpu_rd3), .imm_ext(dec_imm_ext), .rs1(dec_rs1), .rs2(dec_rs2),
        .rs3(dec_rs3), .rd(dec_rd), .funct5(dec_funct5), .rm(dec_rm)
    );

    // flatten control struct
    assign dec_reg_write     = dec_ctrl.reg_write;
    assign dec_fpu_reg_write = dec_ctrl.fpu_reg_write;
    assign dec_mem_write     = dec_ctrl.mem_write;
    assign dec_result_src    = dec_ctrl.result_src;
    assign dec_branch        = dec_ctrl.branch;
    assign dec_jump          = dec_ctrl.jump;
    assign dec_alu_src       = dec_ctrl.alu_src;
    assign dec_alu_ctrl      = dec_ctrl.alu_ctrl;
    assign dec_csr_write     = dec_ctrl.csr_write;
    assign dec_illegal       = dec_ctrl.illegal;

endmodule

// File: sim/decode_tb.sv
`timescale 1ns/1ps

module decode_tb;

    localparam int num_tests = 3000;
    localparam int cycle_limit = num_tests + 200;

    logic        clk = 1'b0;
    logic        rst;
    logic [31:0] instr_in;
    logic        instr_valid;
    logic        stall;
    logic        redirect;
    logic [31:0] redirect_pc;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;
    logic        wb_reg_write;
    logic        wb_fpu_reg_write;

    logic        dec_valid, dec_r4, dec_reg_write, dec_fpu_reg_write, dec_mem_write;
    logic        dec_branch, dec_jump, dec_alu_src, dec_csr_write, dec_illegal;
    logic [1:0]  dec_result_src;
    logic [3:0]  dec_alu_ctrl;
    logic [31:0] dec_pc, dec_pc_plus4, dec_rd1, dec_rd2, dec_imm_ext;
    logic [31:0] dec_fpu_rd1, dec_fpu_rd2, dec_fpu_rd3;
    logic [4:0]  dec_rs1, dec_rs2, dec_rs3, dec_rd, dec_funct5;
    logic [2:0]  dec_rm;

    // reference state
    logic [31:0] seed = 32'hf628_345e;
    logic [31:0] int_regs [32];
    logic [31:0] fp_regs [32];
    logic [31:0] m_pc;
    logic        m_valid;
    logic [31:0] m_pc_q;
    logic [31:0] m_instr_q;
    int          errors = 0;
    int          cycles = 0;

    // supported major opcodes
    logic [6:0] ops [17] = '{7'h33, 7'h13, 7'h03, 7'h23, 7'h63, 7'h6f, 7'h67, 7'h37, 7'h17,
                             7'h73, 7'h07, 7'h27, 7'h53, 7'h43, 7'h47, 7'h4b, 7'h4f};

    decode_top dut0 (.*);

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift();
        seed = seed ^ (seed << 13);
        seed = seed ^ (seed >> 17);
        seed = seed ^ (seed << 5);
        return seed;
    endfunction

    function automatic logic is_fused(input logic [6:0] op);
        return op == 7'h43 || op == 7'h47 || op == 7'h4b || op == 7'h4f;
    endfunction

    // {reg_write fpu_wr mem_write} result_src {branch jump alu_src} alu_ctrl {csr illegal}
    function automatic logic [13:0] expected_ctrl(input logic [31:0] ins);
        logic [3:0]  alu_f;
        logic [4:0]  top;
        logic        fp_to_int;
        logic [13:0] e;
        top = ins[31:27];
        fp_to_int = (top == 5'b10100 || top == 5'b11000 || top == 5'b11100);
        case (ins[14:12])
            3'd0: alu_f = (ins[6:0] == 7'h33 && ins[30]) ? 4'd1 : 4'd0;
            3'd1: alu_f = 4'd2;
            3'd2: alu_f = 4'd3;
            3'd3: alu_f = 4'd4;
            3'd4: alu_f = 4'd5;
            3'd5: alu_f = ins[30] ? 4'd7 : 4'd6;
            3'd6: alu_f = 4'd8;
            default: alu_f = 4'd9;
        endcase
        case (ins[6:0])
            7'h33: e = {3'b100, 2'd0, 3'b000, alu_f, 2'b00};
            7'h13: e = {3'b100, 2'd0, 3'b001, alu_f, 2'b00};
            7'h03: e = {3'b100, 2'd1, 3'b001, 4'd0, 2'b00};
            7'h07: e = {3'b010, 2'd1, 3'b001, 4'd0, 2'b00};
            7'h23, 7'h27: e = {3'b001, 2'd0, 3'b001, 4'd0, 2'b00};
            7'h63: e = {3'b000, 2'd0, 3'b100, 4'd1, 2'b00};
            7'h6f: e = {3'b100, 2'd2, 3'b010, 4'd0, 2'b00};
            7'h67: e = {3'b100, 2'd2, 3'b011, 4'd0, 2'b00};
            7'h37: e = {3'b100, 2'd0, 3'b001, 4'd10, 2'b00};
            7'h17: e = {3'b100, 2'd0, 3'b001, 4'd0, 2'b00};
            7'h73: e = (ins[13:12] != 2'b00) ? {3'b100, 2'd0, 3'b000, 4'd10, 2'b10}
                                             : {12'd0, 2'b01};
            7'h53: e = fp_to_int ? {3'b100, 11'd0} : {3'b010, 11'd0};
            7'h43, 7'h47, 7'h4b, 7'h4f: e = {3'b010, 11'd0};
            default: e = {12'd0, 2'b01};
        endcase
        return e;
    endfunction

    function automatic logic [31:0] expected_imm(input logic [31:0] ins);
        case (ins[6:0])
            7'h23, 7'h27: return {{20{ins[31]}}, ins[31:25], ins[11:7]};
            7'h63: return {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            7'h37, 7'h17: return {ins[31:12], 12'b0};
            7'h6f: return {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            default: return {{20{ins[31]}}, ins[31:20]};
        endcase
    endfunction

    // register read including the write-through from this cycle's write-back
    function automatic logic [31:0] read_int(input logic [4:0] a);
        if (a == 5'd0) return 32'd0;
        if (wb_reg_write && wb_rd == a) return wb_data;
        return int_regs[a];
    endfunction

    function automatic logic [31:0] read_fp(input logic [4:0] a);
        if (wb_fpu_reg_write && wb_rd == a) return wb_data;
        return fp_regs[a];
    endfunction

    task automatic check(input string name, input logic [31:0] act, input logic [31:0] exp);
        if (act !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s actual %h expected %h", $time, name, act, exp);
        end
    endtask

    task automatic check_outputs();
        logic [13:0] ctrl_act;
        logic [31:0] ins;
        ctrl_act = {dec_reg_write, dec_fpu_reg_write, dec_mem_write, dec_result_src,
                    dec_branch, dec_jump, dec_alu_src, dec_alu_ctrl, dec_csr_write,
                    dec_illegal};
        ins = m_instr_q;
        check("dec_valid", 32'(dec_valid), 32'(m_valid));
        if (!m_valid) begin
            check("ctrl idle", 32'(ctrl_act), 32'd0);
            check("r4 idle", 32'(dec_r4), 32'd0);
        end else begin
            check("dec_pc", dec_pc, m_pc_q);
            check("dec_pc_plus4", dec_pc_plus4, m_pc_q + 32'd4);
            check("rs1", 32'(dec_rs1), 32'(ins[19:15]));
            check("rs2", 32'(dec_rs2), 32'(ins[24:20]));
            check("rs3", 32'(dec_rs3), 32'(ins[31:27]));
            check("rd", 32'(dec_rd), 32'(ins[11:7]));
            check("rm", 32'(dec_rm), 32'(ins[14:12]));
            check("imm_ext", dec_imm_ext, expected_imm(ins));
            check("rd1", dec_rd1, read_int(ins[19:15]));
            check("rd2", dec_rd2, read_int(ins[24:20]));
            check("fpu_rd1", dec_fpu_rd1, read_fp(ins[19:15]));
            check("fpu_rd2", dec_fpu_rd2, read_fp(ins[24:20]));
            check("fpu_rd3", dec_fpu_rd3, read_fp(ins[31:27]));
            check("r4", 32'(dec_r4), 32'(is_fused(ins[6:0])));
            check("funct5", 32'(dec_funct5),
                  is_fused(ins[6:0]) ? 32'(ins[6:2]) : 32'(ins[31:27]));
            check("ctrl", 32'(ctrl_act), 32'(expected_ctrl(ins)));
        end
    endtask

    task automatic drive_random();
        logic [31:0] r;
        logic [31:0] w;
        r = xorshift();
        w = xorshift();
        if (r[4:0] > 5'd1) begin
            w[6:0] = ops[r[31:8] % 17];
        end
        instr_in         = w;
        instr_valid      = (r[6:5] != 2'b00);
        stall            = (r[10:7] < 4'd2);
        redirect         = (r[15:11] < 5'd2);
        redirect_pc      = {xorshift() & 32'h0000_fffc};
        r = xorshift();
        wb_rd            = r[4:0];
        wb_reg_write     = r[5];
        wb_fpu_reg_write = r[6];
        wb_data          = xorshift();
    endtask

    // advance fetch pc and fetch/decode register as the next rising edge will
    task automatic step_model();
        logic accept;
        accept = instr_valid && !stall;
        if (wb_reg_write && wb_rd != 5'd0) int_regs[wb_rd] = wb_data;
        if (wb_fpu_reg_write) fp_regs[wb_rd] = wb_data;
        if (!stall) begin
            m_pc_q    = m_pc;
            m_instr_q = instr_in;
        end
        if (redirect) begin
            m_valid = 1'b0;
        end else if (!stall) begin
            m_valid = accept;
        end
        if (redirect) begin
            m_pc = redirect_pc;
        end else if (accept) begin
            m_pc = m_pc + 32'd4;
        end
    endtask

    initial begin
        rst = 1'b1;
        instr_in = '0;
        instr_valid = 1'b0;
        stall = 1'b0;
        redirect = 1'b0;
        redirect_pc = '0;
        wb_rd = '0;
        wb_data = '0;
        wb_reg_write = 1'b0;
        wb_fpu_reg_write = 1'b0;
        for (int i = 0; i < 32; i++) begin
            int_regs[i] = '0;
            fp_regs[i] = '0;
        end
        m_pc = '0;
        m_valid = 1'b0;
        m_pc_q = '0;
        m_instr_q = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int n = 0; n < num_tests; n++) begin
            drive_random();
            // new write-back is on the port but not yet in the array
            #1;
            check_outputs();
            step_model();
            @(negedge clk);
        end
        check_outputs();
        $display("run complete, %0d errors", errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: project.f
verilog/riscv_pkg.sv
verilog/data_fetch_io.sv
verilog/instr_fetch.sv
verilog/fetch_decode_reg.sv
verilog/control_unit.sv
verilog/extend.sv
verilog/regfile.sv
verilog/instr_decode.sv
verilog/decode_top.sv
sim/decode_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module decode_tb -o decode_tb
./obj_dir/decode_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST PASSED" sim.log; then
    exit 0
else
    exit 1
fi
